/* include/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// geometry of the 2-way cache

`define CACHE_SETS    64    // sets per way
`define CACHE_SET_W   6     // log2 of CACHE_SETS

`define CACHE_WORDS   4     // words per block
`define CACHE_OFS_W   2     // log2 of CACHE_WORDS

// tag is what is left of a 32 bit byte address
// above the set index, word offset and byte offset
`define CACHE_TAG_W   22

// data path width, one cpu word
`define CACHE_WORD_W  32

// 22 + 6 + 2 + 2 byte offset bits make the full address
// 4 words of 32 bits make a 128 bit block

`endif

/* logic/cache_addr_pkg.sv */
`include "cache_config.svh"

package cache_addr_pkg;

	localparam int BYTE_OFS_W = 2;                                      // byte within a word
	localparam int ADDR_W = `CACHE_TAG_W + `CACHE_SET_W + `CACHE_OFS_W + BYTE_OFS_W; // 32

	typedef logic [`CACHE_TAG_W-1:0] tag_t;                             // upper address bits
	typedef logic [`CACHE_SET_W-1:0] set_t;                             // selects one of 64 sets
	typedef logic [`CACHE_OFS_W-1:0] ofs_t;                             // word within the block

	// field order is msb first, so tag sits at [31:10]
	typedef struct packed
	{
		tag_t                  tag;                                    // [31:10]
		set_t                  set;                                    // [9:4]
		ofs_t                  ofs;                                    // [3:2]
		logic [BYTE_OFS_W-1:0] byte_ofs;                               // [1:0] ignored by the cache
	} addr_fields_s;

	// one address word seen two ways
	// raw for the memory side and the cpu, fields for the lookup
	typedef union packed
	{
		logic [ADDR_W-1:0] raw;                                        // plain byte address
		addr_fields_s      f;                                          // tag / set / offset split
	} addr_u;

endpackage

/* logic/cache_line_pkg.sv */
`include "cache_config.svh"

package cache_line_pkg;

	// one cpu data word
	typedef logic [`CACHE_WORD_W-1:0] word_t;

	// a block of four words
	// packed with word 0 at the low end so blk[ofs] picks a word
	// word 0 -> [31:0], word 3 -> [127:96]
	typedef word_t [`CACHE_WORDS-1:0] block_t;

	// way index
	// 0 is the first way, 1 the second
	// the lru bit per set holds a way_t too
	typedef logic way_t;

	// way of a two way cache fits in one bit
	localparam way_t WAY0 = 1'b0;                                       // first way
	localparam way_t WAY1 = 1'b1;                                       // second way

	// the storage keeps per set
	//   valid bit
	//   tag
	//   block_t data
	// the controller moves block_t from the memory side into a way
	// and word_t between the cpu and a way

	// width check helpers
	localparam int BLOCK_W = $bits(block_t);                            // 128
	localparam int WORD_W  = $bits(word_t);                             // 32

endpackage

/* logic/cache_way_array.sv */
`include "cache_config.svh"

module cache_way_array
	import cache_addr_pkg::*;
	import cache_line_pkg::*;
(
	input  logic   Rst,                                                 // clock
	input  logic   memwrite2,                                           // async reset, active high

	input  addr_u  lookup_addr,                                         // cpu address to look up

	input  logic   fill_en,                                             // write a whole block
	input  addr_u  fill_addr,                                           // tag and set of the fill
	input  block_t fill_block,                                          // block from memory

	input  logic   word_en,                                             // write one word
	input  addr_u  word_addr,                                           // set and offset of the word
	input  word_t  word_data,                                           // word to write

	output logic   hit,                                                 // valid and tag match
	output block_t block                                                // block of the looked up set
);

	logic [`CACHE_SETS-1:0] valid_q;                                    // one valid bit per set
	tag_t                   tag_mem [`CACHE_SETS];                      // stored tags
	block_t                 data_mem [`CACHE_SETS];                     // stored blocks

	set_t                   look_set;                                   // set under lookup
	set_t                   fill_set;
	set_t                   word_set;
	block_t                 word_block;                                 // block with the new word merged

	assign look_set = lookup_addr.f.set;
	assign fill_set = fill_addr.f.set;
	assign word_set = word_addr.f.set;

	// lookup is purely combinational
	assign hit   = valid_q[look_set] && (tag_mem[look_set] == lookup_addr.f.tag);
	assign block = data_mem[look_set];                                  // controller muxes by hit

	always_ff @(posedge Rst or posedge memwrite2)
	begin
		if (memwrite2)
		begin
			valid_q <= '0;                                              // whole way invalid
		end
		else if (fill_en)
		begin
			valid_q[fill_set] <= 1'b1;                                  // block now present
		end
	end

	// word write starts from the fill block when both hit the same set
	always_comb
	begin
		word_block = data_mem[word_set];
		if (fill_en && (fill_set == word_set))
		begin
			word_block = fill_block;                                    // write miss merge
		end
		word_block[word_addr.f.ofs] = word_data;                        // overlay the cpu word
	end

	always_ff @(posedge Rst)
	begin
		if (fill_en)
		begin
			tag_mem[fill_set]  <= fill_addr.f.tag;
			data_mem[fill_set] <= fill_block;
		end
		if (word_en)
		begin
			data_mem[word_set] <= word_block;                           // wins over the plain fill
		end
	end

endmodule

/* logic/lru_table.sv */
`include "cache_config.svh"

module lru_table
	import cache_addr_pkg::*;
	import cache_line_pkg::*;
(
	input  logic Rst,                                                   // clock
	input  logic memwrite2,                                             // async reset, active high

	input  set_t set,                                                   // set being looked up or filled

	input  logic access_en,                                             // a hit or a fill happened
	input  way_t access_way,                                            // way that was touched

	output way_t victim                                                 // way to replace in this set
);

	// one bit per set
	// holds the least recently used way, 0 = first way
	logic [`CACHE_SETS-1:0] lru_q;

	// victim lookup is combinational on the set
	assign victim = lru_q[set];

	// with two ways the way not touched becomes lru
	always_ff @(posedge Rst or posedge memwrite2)
	begin
		if (memwrite2)
		begin
			lru_q <= '0;                                                // every set points at way 0
		end
		else if (access_en)
		begin
			lru_q[set] <= ~access_way;                                  // other way is now lru
		end
	end

	// hits and fills both arrive here as accesses
	// so a refilled block is never the next victim
	// a read hit on the older block flips the choice back

endmodule

/* logic/cache_ctrl.sv */
module cache_ctrl
	import cache_addr_pkg::*;
	import cache_line_pkg::*;
(
	input  logic   Rst,                                                 // clock
	input  logic   memwrite2,                                           // async reset, active high

	// cpu side
	input  logic   cpu_read,                                            // one cycle read request
	input  logic   cpu_write,                                           // one cycle write request
	input  addr_u  cpu_addr,
	input  word_t  cpu_wdata,
	output word_t  cpu_rdata,
	output logic   cpu_hit,

	// lookup results from the ways
	input  logic   hit0,
	input  logic   hit1,
	input  block_t block0,
	input  block_t block1,
	input  way_t   victim,                                              // lru way of lru_set

	// memory side
	input  logic   fill_ready,                                          // one cycle pulse with the block
	input  block_t fill_data,
	output logic   read_miss,                                           // block fetch pending
	output logic   write_thru,                                          // word write to memory
	output addr_u  mem_addr,
	output word_t  mem_wdata,

	// way and lru control
	output logic   fill0_en,
	output logic   fill1_en,
	output logic   word0_en,
	output logic   word1_en,
	output addr_u  fill_addr,                                           // also the word write address
	output set_t   lru_set,
	output logic   lru_en,
	output way_t   lru_way
);

	typedef enum logic [1:0]
	{
		s_idle,                                                         // taking requests
		s_rd_miss,                                                      // waiting on the fill
		s_wr_miss                                                       // waiting on the fill, then merge
	} state_t;

	state_t state;
	addr_u  addr_q;                                                     // request address
	word_t  wdata_q;                                                    // request write data

	logic   idle_rdy;                                                   // no miss and no write_thru
	logic   accept;                                                     // request taken this cycle
	logic   wr_hit;
	logic   fill_now;                                                   // fill edge of a miss
	logic   merge_now;                                                  // fill edge of a write miss
	block_t hit_block;

	assign idle_rdy = (state == s_idle) && !write_thru;
	assign accept   = idle_rdy && (cpu_read || cpu_write);              // stalled cpu is ignored
	assign wr_hit   = accept && cpu_write && cpu_hit;
	assign fill_now  = read_miss && fill_ready;
	assign merge_now = fill_now && (state == s_wr_miss);

	// hit merge and word select
	assign cpu_hit   = hit0 || hit1;
	assign hit_block = hit0 ? block0 : block1;

	// requested word of the hit block
	assign cpu_rdata = hit_block[cpu_addr.f.ofs];

	// the captured request drives the ways while a miss is open
	assign fill_addr = read_miss ? addr_q : cpu_addr;
	assign lru_set   = fill_addr.f.set;

	assign mem_addr  = addr_q;
	assign mem_wdata = idle_rdy ? cpu_wdata : wdata_q;                  // live only for the hit write

	// fill goes to the lru way
	assign fill0_en = fill_now && (victim == WAY0);
	assign fill1_en = fill_now && (victim == WAY1);
	assign word0_en = (wr_hit && hit0) || (merge_now && (victim == WAY0));
	assign word1_en = (wr_hit && hit1) || (merge_now && (victim == WAY1));

	// hits and fills both touch the lru
	assign lru_en  = (accept && cpu_hit) || fill_now;
	assign lru_way = fill_now ? victim : (hit1 ? WAY1 : WAY0);

	always_ff @(posedge Rst or posedge memwrite2)
	begin
		if (memwrite2)
		begin
			state      <= s_idle;
			read_miss  <= 1'b0;
			write_thru <= 1'b0;
		end
		else
		begin
			case (state)
				s_idle:
				begin
					write_thru <= 1'b0;                                 // write hit pulse is one cycle
					if (accept && cpu_write)
					begin
						write_thru <= 1'b1;                             // every write goes through
						if (!cpu_hit)
						begin
							state     <= s_wr_miss;                     // write allocate
							read_miss <= 1'b1;
						end
					end
					else if (accept && !cpu_hit)
					begin
						state     <= s_rd_miss;
						read_miss <= 1'b1;
					end
				end
				default:
				begin
					if (fill_ready)
					begin
						state      <= s_idle;                           // block is in, cpu retries
						read_miss  <= 1'b0;
						write_thru <= 1'b0;
					end
				end
			endcase
		end
	end

	// request payload
	always_ff @(posedge Rst)
	begin
		if (accept)
		begin
			addr_q  <= cpu_addr;
			wdata_q <= cpu_wdata;
		end
	end

endmodule

/* logic/cache_top.sv */
module cache_top
	import cache_addr_pkg::*;
	import cache_line_pkg::*;
(
	input  logic   Rst,                                                 // clock
	input  logic   memwrite2,                                           // async reset, active high

	// cpu side
	input  logic   cpu_read,
	input  logic   cpu_write,
	input  addr_u  cpu_addr,
	input  word_t  cpu_wdata,
	output word_t  cpu_rdata,
	output logic   cpu_hit,

	// memory side
	output logic   read_miss,
	output logic   write_thru,
	output addr_u  mem_addr,
	output word_t  mem_wdata,
	input  logic   fill_ready,
	input  block_t fill_data
);

	logic   hit0;
	logic   hit1;
	block_t block0;
	block_t block1;
	way_t   victim;
	logic   fill0_en;
	logic   fill1_en;
	logic   word0_en;
	logic   word1_en;
	addr_u  fill_addr;                                                  // fill and word write address
	set_t   lru_set;
	logic   lru_en;
	way_t   lru_way;

	cache_way_array u_way0 (
		.Rst         (Rst),
		.memwrite2   (memwrite2),
		.lookup_addr (cpu_addr),
		.fill_en     (fill0_en),
		.fill_addr   (fill_addr),
		.fill_block  (fill_data),                                       // straight from memory
		.word_en     (word0_en),
		.word_addr   (fill_addr),
		.word_data   (mem_wdata),                                       // cpu word or captured word
		.hit         (hit0),
		.block       (block0)
	);

	cache_way_array u_way1 (
		.Rst         (Rst),
		.memwrite2   (memwrite2),
		.lookup_addr (cpu_addr),
		.fill_en     (fill1_en),
		.fill_addr   (fill_addr),
		.fill_block  (fill_data),
		.word_en     (word1_en),
		.word_addr   (fill_addr),
		.word_data   (mem_wdata),
		.hit         (hit1),
		.block       (block1)
	);

	lru_table u_lru (
		.Rst        (Rst),
		.memwrite2  (memwrite2),
		.set        (lru_set),
		.access_en  (lru_en),
		.access_way (lru_way),
		.victim     (victim)
	);

	cache_ctrl u_ctrl (
		.Rst        (Rst),
		.memwrite2  (memwrite2),
		.cpu_read   (cpu_read),
		.cpu_write  (cpu_write),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_rdata  (cpu_rdata),
		.cpu_hit    (cpu_hit),
		.hit0       (hit0),
		.hit1       (hit1),
		.block0     (block0),
		.block1     (block1),
		.victim     (victim),
		.fill_ready (fill_ready),
		.fill_data  (fill_data),
		.read_miss  (read_miss),
		.write_thru (write_thru),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.fill0_en   (fill0_en),
		.fill1_en   (fill1_en),
		.word0_en   (word0_en),
		.word1_en   (word1_en),
		.fill_addr  (fill_addr),
		.lru_set    (lru_set),
		.lru_en     (lru_en),
		.lru_way    (lru_way)
	);

endmodule

/* dv/mem_model.sv */
`include "cache_config.svh"

module mem_model
	import cache_addr_pkg::*;
	import cache_line_pkg::*;
(
	input  logic   Rst,                                                 // clock
	input  logic   memwrite2,                                           // reset, active high
	input  logic   read_miss,                                           // block fetch request
	input  logic   write_thru,                                          // word write from the cache
	input  addr_u  mem_addr,
	input  word_t  mem_wdata,
	output logic   fill_ready,                                          // one cycle pulse
	output block_t fill_data
);

	integer seed;                                                       // $random state
	int     delay_left;                                                 // cycles until the fill
	logic   busy;                                                       // a miss is being served
	word_t  wt_mem [logic [31:0]];                                      // write-through words by address

	// block around addr, each word is its own byte address unless written
	function automatic block_t make_block(input logic [31:0] addr);
		block_t      blk;
		logic [31:0] base;
		logic [31:0] word_addr;
		int          i;
		base = addr & ~32'(`CACHE_WORDS * 4 - 1);                       // first byte of the block
		for (i = 0; i < `CACHE_WORDS; i++)
		begin
			word_addr = base + 32'(i * 4);
			blk[i[`CACHE_OFS_W-1:0]] = wt_mem.exists(word_addr) ? wt_mem[word_addr] : word_addr;
		end
		return blk;
	endfunction

	// one process, acts 1 time unit after each rising edge
	initial
	begin
		seed       = 32'h4080;
		fill_ready = 1'b0;
		fill_data  = '0;
		busy       = 1'b0;
		delay_left = 0;
		forever
		begin
			@(posedge Rst);
			#1;
			fill_ready = 1'b0;                                          // pulse lasts one cycle
			if (memwrite2)
			begin
				busy       = 1'b0;
				delay_left = 0;
			end
			else
			begin
				if (write_thru && !read_miss)
				begin
					wt_mem[{mem_addr.raw[31:2], 2'b00}] = mem_wdata;    // write hit goes straight in
				end
				if (!read_miss)
				begin
					busy = 1'b0;                                        // miss closed or none open
				end
				else if (!busy)
				begin
					busy       = 1'b1;                                  // read_miss just rose
					delay_left = 1 + int'($unsigned($random(seed)) % 32'd6);
				end
				else if (delay_left > 0)
				begin
					delay_left--;
					if (delay_left == 0)
					begin
						fill_data  = make_block(mem_addr.raw);
						fill_ready = 1'b1;
						if (write_thru)                                 // write miss word lands after the read
						begin
							wt_mem[{mem_addr.raw[31:2], 2'b00}] = mem_wdata;
						end
					end
				end
			end
		end
	end

endmodule

/* dv/tb_cache_top.sv */
`include "cache_config.svh"

module tb_cache_top
	import cache_addr_pkg::*;
	import cache_line_pkg::*;
();

	localparam int MISS_LIMIT = 20;                                     // cycles allowed per miss
	localparam int PROBES     = 8;                                      // random lookups after reset

	logic   Rst = 1'b0;                                                 // clock
	logic   memwrite2;                                                  // reset, active high
	logic   cpu_read;
	logic   cpu_write;
	addr_u  cpu_addr;
	word_t  cpu_wdata;
	word_t  cpu_rdata;
	logic   cpu_hit;
	logic   read_miss;
	logic   write_thru;
	addr_u  mem_addr;
	word_t  mem_wdata;
	logic   fill_ready;
	block_t fill_data;

	integer seed;                                                       // probe address state
	word_t  exp_mem [logic [31:0]];                                     // words written so far

	always #4 Rst = ~Rst;                                               // period 8

	cache_top i_dut (
		.Rst        (Rst),
		.memwrite2  (memwrite2),
		.cpu_read   (cpu_read),
		.cpu_write  (cpu_write),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_rdata  (cpu_rdata),
		.cpu_hit    (cpu_hit),
		.read_miss  (read_miss),
		.write_thru (write_thru),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.fill_ready (fill_ready),
		.fill_data  (fill_data)
	);

	mem_model u_mem (
		.Rst        (Rst),
		.memwrite2  (memwrite2),
		.read_miss  (read_miss),
		.write_thru (write_thru),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.fill_ready (fill_ready),
		.fill_data  (fill_data)
	);

	task automatic value_error(input string msg);
		$display("ERROR at time %0t: %s", $time, msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic miss_timeout(input logic [31:0] addr);
		$display("the miss at address %h never finished within %0d cycles", addr, MISS_LIMIT);
		$display("TEST RESULT: FAIL");
		$fatal(1, "miss timeout");
	endtask

	// memory content: the word address itself unless written
	function automatic word_t expected_word(input logic [31:0] addr);
		logic [31:0] word_addr;
		word_addr = {addr[31:2], 2'b00};
		if (exp_mem.exists(word_addr))
		begin
			return exp_mem[word_addr];
		end
		return word_addr;
	endfunction

	// tag in the top 22 bits, then set, word offset, byte offset
	function automatic logic [31:0] make_addr(input tag_t tag, input set_t set, input ofs_t ofs);
		return {tag, set, ofs, 2'b00};
	endfunction

	task automatic next_drive_slot();
		@(posedge Rst);
		#1;                                                             // inputs move after the edge
	endtask

	task automatic start_request(input logic rd, input logic wr, input logic [31:0] addr,
		input word_t data);
		next_drive_slot();
		cpu_read  = rd;
		cpu_write = wr;
		cpu_addr  = addr;
		cpu_wdata = data;
		@(negedge Rst);                                                 // lookup has settled
	endtask

	task automatic end_request();
		next_drive_slot();                                              // request sampled at this edge
		cpu_read     = 1'b0;
		cpu_write    = 1'b0;
		cpu_addr.raw = ~cpu_addr.raw;                                   // cache keeps its own copy
		cpu_wdata    = ~cpu_wdata;
		@(negedge Rst);
	endtask

	// checks the open miss every cycle until the fill edge
	task automatic wait_fill(input logic [31:0] addr, input logic is_write, input word_t data);
		int   cycles;
		logic filled;
		cycles = 0;
		filled = 1'b0;
		while (!filled && cycles < MISS_LIMIT)
		begin
			assert (read_miss === 1'b1)
			else value_error($sformatf("read_miss low before the fill of %h", addr));
			assert (write_thru === is_write)
			else value_error($sformatf("write_thru %b during miss of %h", write_thru, addr));
			assert (mem_addr.raw === addr)
			else value_error($sformatf("mem_addr %h, expected %h", mem_addr.raw, addr));
			if (is_write)
			begin
				assert (mem_wdata === data)
				else value_error($sformatf("mem_wdata %h, expected %h", mem_wdata, data));
			end
			if (fill_ready === 1'b1)
			begin
				filled = 1'b1;                                          // miss closes at the next edge
			end
			cycles++;
			@(negedge Rst);
		end
		if (filled)
		begin
			assert (read_miss === 1'b0)
			else value_error($sformatf("read_miss still high after the fill of %h", addr));
			assert (write_thru === 1'b0)
			else value_error($sformatf("write_thru still high after the fill of %h", addr));
		end
		else
		begin
			miss_timeout(addr);
		end
	endtask

	task automatic check_read(input logic [31:0] addr, input logic exp_hit);
		start_request(1'b1, 1'b0, addr, '0);
		assert (cpu_hit === exp_hit)
		else value_error($sformatf("read %h cpu_hit %b, expected %b", addr, cpu_hit, exp_hit));
		if (exp_hit)
		begin
			assert (cpu_rdata === expected_word(addr))
			else value_error($sformatf("read %h returned %h, expected %h",
				addr, cpu_rdata, expected_word(addr)));
		end
		end_request();
		if (exp_hit)
		begin
			assert (read_miss === 1'b0 && write_thru === 1'b0)
			else value_error($sformatf("read hit of %h stalled the cpu", addr));
		end
		else
		begin
			wait_fill(addr, 1'b0, '0);
		end
	endtask

	task automatic check_write(input logic [31:0] addr, input word_t data, input logic exp_hit);
		start_request(1'b0, 1'b1, addr, data);
		assert (cpu_hit === exp_hit)
		else value_error($sformatf("write %h cpu_hit %b, expected %b", addr, cpu_hit, exp_hit));
		end_request();
		if (exp_hit)
		begin
			assert (write_thru === 1'b1 && read_miss === 1'b0)
			else value_error($sformatf("write hit of %h: write_thru %b read_miss %b",
				addr, write_thru, read_miss));
			assert (mem_addr.raw === addr)
			else value_error($sformatf("mem_addr %h, expected %h", mem_addr.raw, addr));
			assert (mem_wdata === data)
			else value_error($sformatf("mem_wdata %h, expected %h", mem_wdata, data));
			@(negedge Rst);
			assert (write_thru === 1'b0)
			else value_error($sformatf("write_thru for %h longer than one cycle", addr));
		end
		else
		begin
			wait_fill(addr, 1'b1, data);
		end
		exp_mem[{addr[31:2], 2'b00}] = data;                            // cache and memory both hold it
	endtask

	// every word of a resident block
	task automatic check_block(input logic [31:0] base);
		int k;
		for (k = 0; k < `CACHE_WORDS; k++)
		begin
			check_read(base + 32'(k * 4), 1'b1);
		end
	endtask

	initial
	begin
		logic [31:0] probe;
		logic [31:0] blk_a;
		logic [31:0] blk_b;
		logic [31:0] blk_c;
		int          i;
		seed      = 32'h4080;
		memwrite2 = 1'b1;
		cpu_read  = 1'b0;
		cpu_write = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		repeat (3) @(posedge Rst);
		#1;
		memwrite2 = 1'b0;
		@(negedge Rst);

		// reset state, nothing valid
		assert (read_miss === 1'b0 && write_thru === 1'b0)
		else value_error("read_miss or write_thru high after reset");
		for (i = 0; i < PROBES; i++)
		begin
			probe      = $random(seed);
			probe[1:0] = 2'b00;
			next_drive_slot();
			cpu_addr = probe;                                           // lookup only, no request
			@(negedge Rst);
			assert (cpu_hit === 1'b0)
			else value_error($sformatf("lookup of %h hit after reset", probe));
		end

		// read miss, then the retry hits
		check_read(32'h0000_1234, 1'b0);
		check_read(32'h0000_1234, 1'b1);

		// write hit into that block, neighbours untouched
		check_write(32'h0000_1238, 32'hcafe_0001, 1'b1);
		check_block(32'h0000_1230);

		// write miss allocates and merges
		check_write(32'h0004_5678, 32'h5a5a_1111, 1'b0);
		check_block(32'h0004_5670);

		// lru in a set not used above
		blk_a = make_addr(22'h00001, 6'h3a, 2'd0);
		blk_b = make_addr(22'h00002, 6'h3a, 2'd0);
		blk_c = make_addr(22'h00003, 6'h3a, 2'd0);
		check_read(blk_a, 1'b0);
		check_read(blk_a, 1'b1);
		check_read(blk_b, 1'b0);
		check_read(blk_b, 1'b1);
		check_read(blk_a, 1'b1);                                        // b becomes lru
		check_read(blk_c, 1'b0);                                        // evicts b
		check_read(blk_c, 1'b1);
		check_read(blk_a, 1'b1);
		check_read(blk_b, 1'b0);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* files.f */
+incdir+include
logic/cache_addr_pkg.sv
logic/cache_line_pkg.sv
logic/cache_way_array.sv
logic/lru_table.sv
logic/cache_ctrl.sv
logic/cache_top.sv
dv/mem_model.sv
dv/tb_cache_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_cache_top -o sim_tb

status=0
out=$(./obj_dir/sim_tb 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS"
then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, exit status $status"
exit 1
